// ==== all.f ====
+incdir+include
src/api_cfg_pkg.sv
src/api_data_pkg.sv
src/api_phy_if.sv
src/api_sync_fifo.sv
src/api_timer.sv
src/api_phy.sv
src/api_ctrl.sv
src/api_rx_gate.sv
src/api_top.sv
sim/api_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing
TOP       := api_tb
FILELIST  := all.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== sim/api_tb.sv ====
`timescale 1ns/1ps
`include "api_defs.svh"

module api_tb;
	import api_cfg_pkg::*;
	import api_data_pkg::*;

	localparam int num_rows = 5;
	localparam logic [`API_NUM-1:0] load_off = '1;

	// One run per row with its expected number of kept receive words.
	typedef struct packed {
		logic [5:0]  ch;
		logic [7:0]  wn;
		logic [7:0]  div;
		logic [27:0] timeout;
		logic        drain;
		logic [15:0] kept;
	} row_t;

	logic clk;
	logic rst;
	logic [27:0] reg_timeout;
	logic [7:0] reg_sck;
	logic [5:0] reg_ch_num;
	logic [7:0] reg_word_num;
	logic tx_wr_en;
	tx_word_t tx_din;
	logic tx_full;
	logic rx_rd_en;
	rx_word_t rx_dout;
	logic rx_empty;
	logic [2:0] reg_state;
	logic [`API_NUM-1:0] load;
	logic sck;
	logic mosi;
	logic [`API_NUM-1:0] miso;

	row_t rows [num_rows];
	tx_word_t tx_q [$];
	rx_word_t exp_q [$];
	int errors;
	int checks;
	int cycles;
	int limit;
	bit mon_en;
	bit drain_en;
	bit stalled;
	bit run_armed;
	bit in_run;
	bit run_done;
	int run_start;
	int cur_ch;
	int cur_div;
	int cur_timeout;
	int chip_next;
	int bit_idx;
	int word_idx;
	int kept_cnt;
	int read_cnt;
	int run_len;
	int nop_len;
	logic [`API_NUM-1:0] load_prev;
	logic sck_prev;
	logic rd_pend;
	rx_word_t head_q;

	api_top api_top_i (
		.clk          (clk),
		.rst          (rst),
		.reg_timeout  (reg_timeout),
		.reg_sck      (reg_sck),
		.reg_ch_num   (reg_ch_num),
		.reg_word_num (reg_word_num),
		.tx_wr_en     (tx_wr_en),
		.tx_din       (tx_din),
		.tx_full      (tx_full),
		.rx_rd_en     (rx_rd_en),
		.rx_dout      (rx_dout),
		.rx_empty     (rx_empty),
		.reg_state    (reg_state),
		.load         (load),
		.sck          (sck),
		.mosi         (mosi),
		.miso         (miso)
	);

	// A selected chip echoes the inverse of mosi.
	assign miso = load | ~{`API_NUM{mosi}};

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, want, got);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error at %0t: %s", $time, msg);
		end
	endtask

	task automatic watch_load();
		logic [`API_NUM-1:0] want;
		int free;
		if (load !== load_prev) begin
			if (load === load_off) begin
				check_val("channels per run", chip_next, cur_ch);
				chip_next = 0;
			end else begin
				// Free space as seen before this edge's read.
				free = `API_RX_DEPTH - (kept_cnt - read_cnt);
				want = load_off;
				if (chip_next < `API_NUM) begin
					want[chip_next] = 1'b0;
				end
				check_val("load", load, want);
				check_true(free >= `API_RX_BLOCK_LEN * `API_MAX_CHIP_IN_CH,
					$sformatf("load went low with %0d free receive entries", free));
				chip_next++;
				bit_idx = 0;
				word_idx = 0;
			end
			load_prev = load;
		end
	endtask

	task automatic watch_sck();
		if (sck !== sck_prev) begin
			if (load !== load_off) begin
				if (sck_prev) begin
					check_val("sck high cycles", run_len, cur_div + 1);
				end else begin
					// First low phase of a word includes the start gap.
					if (bit_idx != 0) begin
						check_val("sck low cycles", run_len, cur_div + 1);
					end
					bit_idx++;
					if (bit_idx == `API_WORD_W) begin
						bit_idx = 0;
						if (word_idx % `API_WORK_LEN < `API_RX_BLOCK_LEN) begin
							kept_cnt++;
						end
						word_idx++;
					end
				end
			end
			run_len = 1;
			sck_prev = sck;
		end else begin
			run_len++;
		end
	endtask

	task automatic take_read();
		rx_word_t want;
		if (rd_pend) begin
			read_cnt++;
			if (exp_q.size() == 0) begin
				check_true(1'b0, "receive FIFO returned a word that was not expected");
			end else begin
				want = exp_q.pop_front();
				check_val("rx_dout", head_q, want);
			end
		end
	endtask

	task automatic watch_state();
		if (run_armed && !in_run && reg_state != 3'(st_idle)) begin
			in_run = 1'b1;
			run_start = cycles;
		end else if (in_run && reg_state == 3'(st_idle)) begin
			in_run = 1'b0;
			run_armed = 1'b0;
			run_done = 1'b1;
			check_true(cycles - run_start >= cur_timeout,
				$sformatf("run lasted %0d cycles, shorter than the timer", cycles - run_start));
		end
		// A long wait in nop means the receive FIFO is short of room.
		if (reg_state == 3'(st_nop)) begin
			nop_len++;
		end else begin
			nop_len = 0;
		end
		if (nop_len > 200 && !drain_en) begin
			drain_en = 1'b1;
			stalled = 1'b1;
		end
	endtask

	task automatic drive_host();
		tx_wr_en = 1'b0;
		if (tx_q.size() != 0 && !tx_full) begin
			tx_din = tx_q.pop_front();
			tx_wr_en = 1'b1;
		end
		rd_pend = drain_en && !rx_empty;
		rx_rd_en = rd_pend;
		head_q = rx_dout;
	endtask

	always begin
		@(posedge clk);
		#1;
		cycles++;
		if (mon_en) begin
			watch_load();
			watch_sck();
			take_read();
			watch_state();
		end
		drive_host();
	end

	initial begin
		wait (limit != 0);
		while (cycles < limit) begin
			@(posedge clk);
		end
		$display("Timeout, the run did not finish within %0d cycles", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int r;
		int c;
		int w;
		int reads_start;
		tx_word_t word;
		void'($urandom(32'hd39c));
		rst = 1'b1;
		reg_timeout = '0;
		reg_sck = '0;
		reg_ch_num = '0;
		reg_word_num = '0;
		tx_wr_en = 1'b0;
		tx_din = '0;
		rx_rd_en = 1'b0;
		rd_pend = 1'b0;
		load_prev = load_off;
		sck_prev = 1'b0;
		rows[0] = '{ch: 6'd1, wn: 8'd5, div: 8'd2, timeout: 28'd100, drain: 1'b1, kept: 16'd5};
		rows[1] = '{ch: 6'd1, wn: 8'd20, div: 8'd0, timeout: 28'd3000, drain: 1'b1, kept: 16'd11};
		rows[2] = '{ch: 6'd4, wn: 8'd30, div: 8'd1, timeout: 28'd50, drain: 1'b1, kept: 16'd72};
		rows[3] = '{ch: 6'd3, wn: 8'd230, div: 8'd0, timeout: 28'd10, drain: 1'b0, kept: 16'd330};
		rows[4] = '{ch: 6'd2, wn: 8'd24, div: 8'd3, timeout: 28'd20, drain: 1'b1, kept: 16'd24};
		limit = 5000;
		for (r = 0; r < num_rows; r++) begin
			limit += (int'(rows[r].ch) * int'(rows[r].wn) + 1) * 64 * (int'(rows[r].div) + 1)
				+ int'(rows[r].timeout) + 2000;
		end

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_val("load", load, load_off);
		check_val("reg_state", reg_state, 3'(st_idle));
		check_val("rx_empty", rx_empty, 1'b1);
		check_val("tx_full", tx_full, 1'b0);
		check_val("sck", sck, 1'b0);
		check_val("mosi", mosi, 1'b0);
		sck_prev = sck;
		mon_en = 1'b1;

		for (r = 0; r < num_rows; r++) begin
			@(posedge clk);
			#1;
			reg_timeout = rows[r].timeout;
			reg_sck = rows[r].div;
			reg_ch_num = rows[r].ch;
			reg_word_num = rows[r].wn;
			@(negedge clk);
			cur_ch = int'(rows[r].ch);
			cur_div = int'(rows[r].div);
			cur_timeout = int'(rows[r].timeout);
			for (c = 0; c < cur_ch; c++) begin
				for (w = 0; w < int'(rows[r].wn); w++) begin
					word = $urandom();
					tx_q.push_back(word);
					// Head of each block comes back inverted.
					if (w % `API_WORK_LEN < `API_RX_BLOCK_LEN) begin
						exp_q.push_back(~word);
					end
				end
			end
			reads_start = read_cnt;
			drain_en = rows[r].drain;
			stalled = 1'b0;
			run_done = 1'b0;
			run_armed = 1'b1;
			while (!run_done) begin
				@(negedge clk);
			end
			drain_en = 1'b1;
			while (exp_q.size() != 0) begin
				@(negedge clk);
			end
			repeat (4) @(negedge clk);
			check_val("rx_empty", rx_empty, 1'b1);
			check_val("receive words read", read_cnt - reads_start, rows[r].kept);
			if (!rows[r].drain) begin
				check_true(stalled, "sequencer never waited for receive headroom");
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== src/api_top.sv ====
`timescale 1ns/1ps
`include "api_defs.svh"

module api_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [27:0]             reg_timeout,
	input  logic [7:0]              reg_sck,
	input  logic [5:0]              reg_ch_num,
	input  logic [7:0]              reg_word_num,
	input  logic                    tx_wr_en,
	input  api_data_pkg::tx_word_t  tx_din,
	output logic                    tx_full,
	input  logic                    rx_rd_en,
	output api_data_pkg::rx_word_t  rx_dout,
	output logic                    rx_empty,
	output logic [2:0]              reg_state,
	output logic [`API_NUM-1:0]     load,
	output logic                    sck,
	output logic                    mosi,
	input  logic [`API_NUM-1:0]     miso
);
	import api_cfg_pkg::*;
	import api_data_pkg::*;

	api_cfg_t cfg;
	seq_state_t state;
	tx_word_t tx_dout;
	rx_word_t rx_din;
	logic tx_empty;
	logic tx_rd_en;
	logic rx_wr_en;
	logic [$clog2(`API_RX_DEPTH):0] rx_count;
	logic timer_start;
	logic timer_busy;
	logic work;
	logic miso_w;

	api_phy_if word_if ();

	assign cfg = '{timeout: reg_timeout, sck_div: reg_sck,
		ch_num: reg_ch_num, word_num: reg_word_num};
	assign reg_state = {1'b0, state};
	assign word_if.mosi_dat = tx_dout;
	assign tx_rd_en = word_if.mosi_vld && state == st_work;

	// Unselected chips read as ones.
	assign miso_w = &(miso | load);

	api_sync_fifo #(
		.item_t (tx_word_t),
		.depth  (`API_TX_DEPTH)
	) tx_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (tx_wr_en),
		.din        (tx_din),
		.rd_en      (tx_rd_en),
		.dout       (tx_dout),
		.empty      (tx_empty),
		.full       (tx_full),
		.data_count ()
	);

	api_sync_fifo #(
		.item_t (rx_word_t),
		.depth  (`API_RX_DEPTH)
	) rx_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (rx_wr_en),
		.din        (rx_din),
		.rd_en      (rx_rd_en),
		.dout       (rx_dout),
		.empty      (rx_empty),
		.full       (),
		.data_count (rx_count)
	);

	api_ctrl api_ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.cfg         (cfg),
		.tx_empty    (tx_empty),
		.rx_count    (rx_count),
		.timer_busy  (timer_busy),
		.timer_start (timer_start),
		.word        (word_if.seq),
		.work        (work),
		.state       (state),
		.load        (load)
	);

	api_timer api_timer_i (
		.clk     (clk),
		.rst     (rst),
		.timeout (cfg.timeout),
		.start   (timer_start),
		.busy    (timer_busy)
	);

	api_phy api_phy_i (
		.clk     (clk),
		.rst     (rst),
		.sck_div (cfg.sck_div),
		.word    (word_if.phy),
		.sck     (sck),
		.mosi    (mosi),
		.miso    (miso_w)
	);

	api_rx_gate api_rx_gate_i (
		.clk      (clk),
		.rst      (rst),
		.work     (work),
		.word     (word_if.res),
		.rx_wr_en (rx_wr_en),
		.rx_din   (rx_din)
	);

endmodule

// ==== src/api_rx_gate.sv ====
`timescale 1ns/1ps
`include "api_defs.svh"

module api_rx_gate (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    work,
	api_phy_if.res                  word,
	output logic                    rx_wr_en,
	output api_data_pkg::rx_word_t  rx_din
);
	localparam int pos_w = $clog2(`API_WORK_LEN);

	logic work_q;
	logic [pos_w-1:0] pos;
	logic block_end;

	assign block_end = pos == pos_w'(`API_WORK_LEN - 1);

	// Keep only the head of each block.
	assign rx_wr_en = work && word.miso_vld && pos < pos_w'(`API_RX_BLOCK_LEN);
	assign rx_din = word.miso_dat;

	always_ff @(posedge clk) begin
		if (rst) begin
			work_q <= 1'b0;
			pos <= '0;
		end else begin
			work_q <= work;
			if (work && !work_q) begin
				pos <= '0;
			end else if (work && word.miso_vld) begin
				pos <= block_end ? '0 : pos + 1'b1;
			end
		end
	end

endmodule

// ==== src/api_ctrl.sv ====
`timescale 1ns/1ps
`include "api_defs.svh"

module api_ctrl (
	input  logic                           clk,
	input  logic                           rst,
	input  api_cfg_pkg::api_cfg_t          cfg,
	input  logic                           tx_empty,
	input  logic [$clog2(`API_RX_DEPTH):0] rx_count,
	input  logic                           timer_busy,
	output logic                           timer_start,
	api_phy_if.seq                         word,
	output logic                           work,
	output api_cfg_pkg::seq_state_t        state,
	output logic [`API_NUM-1:0]            load
);
	import api_cfg_pkg::*;

	localparam int cnt_w = $clog2(`API_RX_DEPTH) + 1;
	localparam int gap_w = $clog2(`API_LOAD_GAP + 1);
	localparam int rx_need = `API_RX_BLOCK_LEN * `API_MAX_CHIP_IN_CH;

	seq_state_t nxt;
	logic [cnt_w-1:0] rx_free;
	logic rx_ok;
	logic can_start;
	logic enter_work;
	logic enter_done;
	logic gap_full;
	logic more_words;
	logic [5:0] ch_cnt;
	logic [7:0] word_cnt;
	logic [8:0] word_next;
	logic [gap_w-1:0] gap_cnt;
	logic load_back;

	assign rx_free = cnt_w'(`API_RX_DEPTH) - rx_count;
	assign rx_ok = rx_free >= cnt_w'(rx_need);
	assign can_start = !tx_empty && rx_ok;
	assign gap_full = gap_cnt == gap_w'(`API_LOAD_GAP);
	assign word_next = {1'b0, word_cnt} + 9'd1;
	assign more_words = word_next < {1'b0, cfg.word_num};
	assign enter_work = state != st_work && nxt == st_work;
	assign enter_done = state != st_done && nxt == st_done;
	assign timer_start = state == st_idle && nxt != st_idle;
	assign work = state == st_work;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= nxt;
		end
	end

	always_comb begin
		nxt = state;
		case (state)
			st_idle: if (can_start) nxt = st_work;
			st_work: if (word_cnt == cfg.word_num) nxt = st_nop;
			st_nop: begin
				// Channel count of zero behaves as one.
				if (gap_full && ch_cnt >= cfg.ch_num) begin
					nxt = st_done;
				end else if (gap_full && can_start) begin
					nxt = st_work;
				end
			end
			st_done: if (!timer_busy && load_back) nxt = st_idle;
			default: nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			word_cnt <= '0;
		end else if (enter_work) begin
			word_cnt <= '0;
		end else if (work && word.miso_vld && word_cnt != cfg.word_num) begin
			word_cnt <= word_cnt + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ch_cnt <= '0;
		end else if (nxt == st_idle) begin
			ch_cnt <= '0;
		end else if (enter_work) begin
			ch_cnt <= ch_cnt + 6'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || state != st_nop) begin
			gap_cnt <= '0;
		end else if (!gap_full) begin
			gap_cnt <= gap_cnt + 1'b1;
		end
	end

	// One extra transfer on entering done pushes the final load.
	always_ff @(posedge clk) begin
		if (rst) begin
			word.mosi_vld <= 1'b0;
		end else begin
			word.mosi_vld <= enter_work || enter_done ||
				(work && word.miso_vld && more_words);
		end
	end

	always_ff @(posedge clk) begin
		if (rst || state == st_idle) begin
			load_back <= 1'b0;
		end else if (state == st_done && word.miso_vld) begin
			load_back <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			load <= '1;
		end else if (state == st_idle && nxt == st_work) begin
			load <= {{(`API_NUM - 1){1'b1}}, 1'b0};
		end else if (state == st_nop && nxt == st_work) begin
			load <= {load[`API_NUM-2:0], 1'b1};
		end else if (enter_done) begin
			load <= '1;
		end
	end

endmodule

// ==== src/api_phy.sv ====
`timescale 1ns/1ps
`include "api_defs.svh"

module api_phy (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] sck_div,
	api_phy_if.phy     word,
	output logic       sck,
	output logic       mosi,
	input  logic       miso
);
	import api_data_pkg::*;

	localparam int bit_w = $clog2(`API_WORD_W);

	tx_word_t tx_sh;
	rx_word_t rx_sh;
	logic busy;
	logic start;
	logic [7:0] div_cnt;
	logic [bit_w-1:0] bit_cnt;
	logic half_end;
	logic last_bit;

	assign start = word.mosi_vld && !busy;
	assign half_end = busy && div_cnt == sck_div;
	assign last_bit = bit_cnt == bit_w'(`API_WORD_W - 1);

	// Data line is held low between words.
	assign mosi = busy && tx_sh[`API_WORD_W-1];

	// Word ends on the last falling edge.
	assign word.miso_vld = half_end && sck && last_bit;
	assign word.miso_dat = rx_sh;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			sck <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			sck <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (busy) begin
			if (half_end) begin
				div_cnt <= '0;
				sck <= !sck;
				if (sck) begin
					if (last_bit) begin
						busy <= 1'b0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			tx_sh <= word.mosi_dat;
		end else if (half_end && sck) begin
			tx_sh <= {tx_sh[`API_WORD_W-2:0], 1'b0};
		end
		// Sample on the rising edge.
		if (half_end && !sck) begin
			rx_sh <= {rx_sh[`API_WORD_W-2:0], miso};
		end
	end

endmodule

// ==== src/api_timer.sv ====
`timescale 1ns/1ps

module api_timer (
	input  logic        clk,
	input  logic        rst,
	input  logic [27:0] timeout,
	input  logic        start,
	output logic        busy
);
	logic [27:0] remain;

	// Busy for exactly timeout cycles after start.
	assign busy = remain != '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			remain <= '0;
		end else if (start) begin
			remain <= timeout;
		end else if (busy) begin
			remain <= remain - 28'd1;
		end
	end

endmodule

// ==== src/api_sync_fifo.sv ====
`timescale 1ns/1ps

module api_sync_fifo #(
	parameter type item_t = logic [31:0],
	parameter int depth = 16
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wr_en,
	input  item_t                  din,
	input  logic                   rd_en,
	output item_t                  dout,
	output logic                   empty,
	output logic                   full,
	output logic [$clog2(depth):0] data_count
);
	localparam int ptr_w = $clog2(depth);

	item_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic wr_ok;
	logic rd_ok;

	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;
	assign empty = data_count == '0;
	assign full = data_count == (ptr_w + 1)'(depth);

	// Head entry is always on dout.
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			data_count <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10: data_count <= data_count + 1'b1;
				2'b01: data_count <= data_count - 1'b1;
				default: data_count <= data_count;
			endcase
		end
	end

endmodule

// ==== src/api_phy_if.sv ====
`timescale 1ns/1ps

interface api_phy_if;
	import api_data_pkg::*;

	logic     mosi_vld;
	tx_word_t mosi_dat;
	logic     miso_vld;
	rx_word_t miso_dat;

	modport seq (
		output mosi_vld,
		input  miso_vld
	);

	modport phy (
		input  mosi_vld,
		input  mosi_dat,
		output miso_vld,
		output miso_dat
	);

	modport res (
		input miso_vld,
		input miso_dat
	);

endinterface

// ==== src/api_data_pkg.sv ====
`include "api_defs.svh"

package api_data_pkg;

	// Command word as written by the host.
	typedef logic [`API_WORD_W-1:0] tx_word_t;

	// Word shifted back from the chain.
	typedef logic [`API_WORD_W-1:0] rx_word_t;

endpackage

// ==== src/api_cfg_pkg.sv ====
package api_cfg_pkg;

	// Sequencer states.
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_work = 2'd1,
		st_nop  = 2'd2,
		st_done = 2'd3
	} seq_state_t;

	// Host configuration levels, held steady during a run.
	typedef struct packed {
		logic [27:0] timeout;
		logic [7:0]  sck_div;
		logic [5:0]  ch_num;
		logic [7:0]  word_num;
	} api_cfg_t;

endpackage

// ==== include/api_defs.svh ====
`ifndef API_DEFS_SVH
`define API_DEFS_SVH

// Chain size and word width.
`define API_NUM            4
`define API_WORD_W         32

// FIFO depths in words.
`define API_TX_DEPTH       64
`define API_RX_DEPTH       256

// Block layout in words.
`define API_WORK_LEN       23
`define API_RX_BLOCK_LEN   11

// Blocks of receive headroom needed before a channel starts.
`define API_MAX_CHIP_IN_CH 5

// Idle cycles between two channel bursts.
`define API_LOAD_GAP       15

`endif
